// ==== spi_adc_pkg.sv ====
// logger constants, adc config word, range thresholds, state and range enums
package spi_adc_pkg;

    // adc reading and framing sizes
    localparam int CODE_W            = 18;  // one adc reading
    localparam int BYTES_PER_SAMPLE  = 4;   // bytes per adc transaction and per packed sample
    localparam int SAMPLES_PER_FRAME = 10;
    localparam int FRAME_BYTES       = BYTES_PER_SAMPLE * SAMPLES_PER_FRAME;  // 40
    localparam int FRAME_ADDR_W      = 6;   // covers 0..39

    // 1.25x unipolar setup, MSB byte first on the wire
    localparam logic [31:0] ADC_CONFIG_WORD = 32'hD014_000B;

    // autorange thresholds on the raw code
    localparam logic [CODE_W-1:0] RANGE_LIMIT_LOW  = CODE_W'(2100);
    localparam logic [CODE_W-1:0] RANGE_LIMIT_HIGH = CODE_W'(220000);

    // measurement ranges, mA is the widest
    typedef enum logic [1:0] {
        RANGE_MA,
        RANGE_UA,
        RANGE_NA
    } range_e;

    // adc transaction FSM
    typedef enum logic [1:0] {
        ADC_IDLE,    // waiting on period tick
        ADC_STROBE,  // convst high
        ADC_SHIFT,   // four bytes under cs_n
        ADC_DONE     // sample_valid out
    } adc_state_e;

    // mcu frame FSM
    typedef enum logic [1:0] {
        STREAM_IDLE,
        STREAM_SHIFT,
        STREAM_END
    } stream_state_e;

endpackage

// ==== spi_byte_master.sv ====
// spi_byte_master: mode-0 full-duplex SPI master, one byte per request
module spi_byte_master #(
    parameter int CLKS_PER_HALF_BIT = 2
) (
    input  logic       CLK,
    input  logic       r_spi_master_adc_reset,
    input  logic [7:0] i_tx_byte,
    input  logic       i_tx_dv,      // one-cycle request
    output logic       o_tx_ready,
    output logic       o_rx_dv,      // one-cycle, byte done
    output logic [7:0] o_rx_byte,
    output logic       o_spi_clk,
    output logic       o_spi_mosi,
    input  logic       i_spi_miso
);

    localparam int HALF_W = $clog2(CLKS_PER_HALF_BIT + 1);

    logic              r_busy;
    logic [HALF_W-1:0] r_half_cnt;   // clocks within a half bit
    logic [4:0]        r_edges_left; // 16 sclk edges per byte
    logic [7:0]        r_tx_shift;
    logic [7:0]        r_rx_shift;
    logic              w_half_done;

    assign w_half_done = (r_half_cnt == HALF_W'(CLKS_PER_HALF_BIT - 1));
    assign o_tx_ready  = ~r_busy;
    assign o_rx_byte   = r_rx_shift;  // complete when o_rx_dv pulses

    always_ff @(posedge CLK) begin
        if (!r_spi_master_adc_reset) begin
            r_busy       <= 1'b0;
            r_half_cnt   <= '0;
            r_edges_left <= '0;
            o_rx_dv      <= 1'b0;
            o_spi_clk    <= 1'b0;  // cpol 0
            o_spi_mosi   <= 1'b0;
        end else begin
            o_rx_dv <= 1'b0;
            if (i_tx_dv && !r_busy) begin
                r_busy       <= 1'b1;
                r_half_cnt   <= '0;
                r_edges_left <= 5'd16;
                o_spi_mosi   <= i_tx_byte[7];  // msb ahead of first rising edge
            end else if (r_busy) begin
                if (w_half_done) begin
                    r_half_cnt   <= '0;
                    o_spi_clk    <= ~o_spi_clk;
                    r_edges_left <= r_edges_left - 5'd1;
                    if (o_spi_clk) begin
                        o_spi_mosi <= r_tx_shift[7];  // falling edge, next bit out
                    end
                    if (r_edges_left == 5'd1) begin
                        r_busy  <= 1'b0;  // last falling edge
                        o_rx_dv <= 1'b1;
                    end
                end else begin
                    r_half_cnt <= r_half_cnt + HALF_W'(1);
                end
            end
        end
    end

    // shift registers, payload only
    always_ff @(posedge CLK) begin
        if (i_tx_dv && !r_busy) begin
            r_tx_shift <= {i_tx_byte[6:0], 1'b0};
        end else if (r_busy && w_half_done) begin
            if (o_spi_clk) begin
                r_tx_shift <= {r_tx_shift[6:0], 1'b0};
            end else begin
                r_rx_shift <= {r_rx_shift[6:0], i_spi_miso};  // rising edge sample
            end
        end
    end

    // callers must wait for ready, a request while busy is lost
    a_no_req_while_busy: assert property (
        @(posedge CLK) disable iff (!r_spi_master_adc_reset)
        i_tx_dv |-> o_tx_ready
    );

endmodule

// ==== adc_sampler.sv ====
// conversion timer, one-time config, 4-byte adc read and code extraction
module adc_sampler #(
    parameter int CONV_PERIOD       = 400,
    parameter int CLKS_PER_HALF_BIT = 2
) (
    input  logic                            CLK,
    input  logic                            r_spi_master_adc_reset,
    output logic                            o_adc_convst,
    output logic                            o_adc_cs_n,
    output logic                            o_adc_sclk,
    output logic                            o_adc_mosi,
    input  logic                            i_adc_miso,
    output logic                            o_sample_valid,
    output logic [spi_adc_pkg::CODE_W-1:0]  o_sample_code
);

    localparam int PERIOD_W = $clog2(CONV_PERIOD);

    spi_adc_pkg::adc_state_e r_state;

    logic [PERIOD_W-1:0] r_period_cnt;
    logic                r_configured;  // config word already sent
    logic [1:0]          r_byte_cnt;    // received bytes in this window
    logic [31:0]         r_tx_word;     // top byte goes out next
    logic [23:0]         r_rx_word;     // bytes 0..2 only
    logic                r_tx_dv;
    logic                w_tick;
    logic                w_rx_dv;
    logic [7:0]          w_rx_byte;
    logic                w_last_byte;

    assign w_tick      = (r_period_cnt == PERIOD_W'(CONV_PERIOD - 1));
    assign w_last_byte = (r_byte_cnt == 2'(spi_adc_pkg::BYTES_PER_SAMPLE - 1));

    // free-running conversion period
    always_ff @(posedge CLK) begin
        if (!r_spi_master_adc_reset) begin
            r_period_cnt <= '0;
        end else if (w_tick) begin
            r_period_cnt <= '0;
        end else begin
            r_period_cnt <= r_period_cnt + PERIOD_W'(1);
        end
    end

    always_ff @(posedge CLK) begin
        if (!r_spi_master_adc_reset) begin
            r_state        <= spi_adc_pkg::ADC_IDLE;
            r_configured   <= 1'b0;
            r_byte_cnt     <= '0;
            r_tx_dv        <= 1'b0;
            o_adc_convst   <= 1'b0;
            o_adc_cs_n     <= 1'b1;
            o_sample_valid <= 1'b0;
        end else begin
            r_tx_dv        <= 1'b0;  // strobes by default
            o_sample_valid <= 1'b0;
            case (r_state)
                spi_adc_pkg::ADC_IDLE: begin
                    if (w_tick) begin
                        o_adc_convst <= 1'b1;
                        r_state      <= spi_adc_pkg::ADC_STROBE;
                    end
                end
                spi_adc_pkg::ADC_STROBE: begin
                    o_adc_convst <= 1'b0;   // single cycle strobe
                    o_adc_cs_n   <= 1'b0;
                    r_byte_cnt   <= '0;
                    r_tx_dv      <= 1'b1;   // first byte with cs_n
                    r_state      <= spi_adc_pkg::ADC_SHIFT;
                end
                spi_adc_pkg::ADC_SHIFT: begin
                    if (w_rx_dv) begin
                        if (w_last_byte) begin
                            o_adc_cs_n     <= 1'b1;
                            o_sample_valid <= 1'b1;
                            r_configured   <= 1'b1;
                            r_state        <= spi_adc_pkg::ADC_DONE;
                        end else begin
                            r_byte_cnt <= r_byte_cnt + 2'd1;
                            r_tx_dv    <= 1'b1;  // back to back
                        end
                    end
                end
                default: begin  // ADC_DONE while valid is out
                    r_state <= spi_adc_pkg::ADC_IDLE;
                end
            endcase
        end
    end

    // tx word shift and rx byte capture
    always_ff @(posedge CLK) begin
        if (r_state == spi_adc_pkg::ADC_STROBE) begin
            r_tx_word <= r_configured ? 32'h0 : spi_adc_pkg::ADC_CONFIG_WORD;
        end else if (w_rx_dv) begin
            r_tx_word <= {r_tx_word[23:0], 8'h00};
        end
        if (w_rx_dv && !w_last_byte) begin
            r_rx_word <= {r_rx_word[15:0], w_rx_byte};
        end
        if (w_rx_dv && w_last_byte) begin
            o_sample_code <= r_rx_word[23:6];  // byte0, byte1, byte2[7:6]
        end
    end

    spi_byte_master #(
        .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
    ) u_adc_spi (
        .CLK                    (CLK),
        .r_spi_master_adc_reset (r_spi_master_adc_reset),
        .i_tx_byte              (r_tx_word[31:24]),
        .i_tx_dv                (r_tx_dv),
        .o_tx_ready             (),
        .o_rx_dv                (w_rx_dv),
        .o_rx_byte              (w_rx_byte),
        .o_spi_clk              (o_adc_sclk),
        .o_spi_mosi             (o_adc_mosi),
        .i_spi_miso             (i_adc_miso)
    );

    // adc window must end before the next period tick
    a_tick_while_busy: assert property (
        @(posedge CLK) disable iff (!r_spi_master_adc_reset)
        (w_tick && r_state != spi_adc_pkg::ADC_IDLE) |-> 1'b0
    );

endmodule

// ==== range_framer.sv ====
// autorange ladder, sample packing, ping-pong frame banks and read port
module range_framer (
    input  logic                                  CLK,
    input  logic                                  r_spi_master_adc_reset,
    input  logic                                  i_sample_valid,
    input  logic [spi_adc_pkg::CODE_W-1:0]        i_sample_code,
    input  logic [spi_adc_pkg::FRAME_ADDR_W-1:0]  i_rd_addr,
    output logic [7:0]                            o_rd_byte,
    output logic                                  o_range_ma,
    output logic                                  o_range_ua,
    output logic                                  o_range_na,
    output logic                                  o_frame_ready
);

    localparam int FB = spi_adc_pkg::FRAME_BYTES;
    localparam int AW = spi_adc_pkg::FRAME_ADDR_W;

    spi_adc_pkg::range_e r_range;
    spi_adc_pkg::range_e w_range_next;

    logic [7:0]  r_bank0 [0:FB-1];
    logic [7:0]  r_bank1 [0:FB-1];
    logic        r_fill_bank;     // bank taking samples
    logic [3:0]  r_idx;           // sample index 0..9
    logic [31:0] w_sample;        // packed 4 bytes
    logic [AW-1:0] w_base;

    assign o_range_ma = (r_range == spi_adc_pkg::RANGE_MA);
    assign o_range_ua = (r_range == spi_adc_pkg::RANGE_UA);
    assign o_range_na = (r_range == spi_adc_pkg::RANGE_NA);

    // tag carries the range before the update
    assign w_sample = {o_range_ma, o_range_ua, o_range_na, 1'b0, r_idx, 6'b0, i_sample_code};
    assign w_base   = {r_idx, 2'b00};

    // streamer reads the completed bank
    assign o_rd_byte = r_fill_bank ? r_bank0[i_rd_addr] : r_bank1[i_rd_addr];

    // one ladder step per sample with the high limit first
    always_comb begin
        w_range_next = r_range;
        if (i_sample_code >= spi_adc_pkg::RANGE_LIMIT_HIGH) begin
            if (r_range == spi_adc_pkg::RANGE_NA) w_range_next = spi_adc_pkg::RANGE_UA;
            if (r_range == spi_adc_pkg::RANGE_UA) w_range_next = spi_adc_pkg::RANGE_MA;
        end else if (i_sample_code <= spi_adc_pkg::RANGE_LIMIT_LOW) begin
            if (r_range == spi_adc_pkg::RANGE_MA) w_range_next = spi_adc_pkg::RANGE_UA;
            if (r_range == spi_adc_pkg::RANGE_UA) w_range_next = spi_adc_pkg::RANGE_NA;
        end
    end

    always_ff @(posedge CLK) begin
        if (!r_spi_master_adc_reset) begin
            r_range       <= spi_adc_pkg::RANGE_MA;
            r_idx         <= '0;
            r_fill_bank   <= 1'b0;
            o_frame_ready <= 1'b0;
        end else begin
            o_frame_ready <= 1'b0;
            if (i_sample_valid) begin
                r_range <= w_range_next;
                if (r_idx == 4'(spi_adc_pkg::SAMPLES_PER_FRAME - 1)) begin
                    r_idx         <= '0;
                    r_fill_bank   <= ~r_fill_bank;  // frame done so swap banks
                    o_frame_ready <= 1'b1;
                end else begin
                    r_idx <= r_idx + 4'd1;
                end
            end
        end
    end

    // all four bytes land in one cycle msb first
    always_ff @(posedge CLK) begin
        if (i_sample_valid) begin
            for (int k = 0; k < spi_adc_pkg::BYTES_PER_SAMPLE; k++) begin
                if (r_fill_bank) begin
                    r_bank1[w_base + AW'(k)] <= w_sample[31 - 8*k -: 8];
                end else begin
                    r_bank0[w_base + AW'(k)] <= w_sample[31 - 8*k -: 8];
                end
            end
        end
    end

    a_range_onehot: assert property (
        @(posedge CLK) disable iff (!r_spi_master_adc_reset)
        $onehot({o_range_ma, o_range_ua, o_range_na})
    );

endmodule

// ==== mcu_streamer.sv ====
// mcu_streamer: sends each completed 40-byte frame to the MCU under one chip select
module mcu_streamer #(
    parameter int CLKS_PER_HALF_BIT = 2
) (
    input  logic                                  CLK,
    input  logic                                  r_spi_master_adc_reset,
    input  logic                                  i_frame_ready,
    output logic [spi_adc_pkg::FRAME_ADDR_W-1:0]  o_rd_addr,
    input  logic [7:0]                            i_rd_byte,
    output logic                                  o_mcu_cs_n,
    output logic                                  o_mcu_sclk,
    output logic                                  o_mcu_mosi
);

    localparam int AW = spi_adc_pkg::FRAME_ADDR_W;

    spi_adc_pkg::stream_state_e r_state;

    logic r_tx_dv;
    logic w_tx_ready;
    logic w_rx_dv;

    always_ff @(posedge CLK) begin
        if (!r_spi_master_adc_reset) begin
            r_state    <= spi_adc_pkg::STREAM_IDLE;
            o_rd_addr  <= '0;
            o_mcu_cs_n <= 1'b1;
            r_tx_dv    <= 1'b0;
        end else begin
            r_tx_dv <= 1'b0;
            case (r_state)
                spi_adc_pkg::STREAM_IDLE: begin
                    if (i_frame_ready) begin
                        o_rd_addr  <= '0;
                        o_mcu_cs_n <= 1'b0;
                        r_tx_dv    <= 1'b1;  // byte 0 with cs_n
                        r_state    <= spi_adc_pkg::STREAM_SHIFT;
                    end
                end
                spi_adc_pkg::STREAM_SHIFT: begin
                    if (w_rx_dv) begin
                        if (o_rd_addr == AW'(spi_adc_pkg::FRAME_BYTES - 1)) begin
                            r_state <= spi_adc_pkg::STREAM_END;
                        end else begin
                            o_rd_addr <= o_rd_addr + AW'(1);
                            r_tx_dv   <= 1'b1;
                        end
                    end
                end
                default: begin  // STREAM_END, release cs
                    o_mcu_cs_n <= 1'b1;
                    r_state    <= spi_adc_pkg::STREAM_IDLE;
                end
            endcase
        end
    end

    spi_byte_master #(
        .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
    ) u_mcu_spi (
        .CLK                    (CLK),
        .r_spi_master_adc_reset (r_spi_master_adc_reset),
        .i_tx_byte              (i_rd_byte),  // read port is combinational
        .i_tx_dv                (r_tx_dv),
        .o_tx_ready             (w_tx_ready),
        .o_rx_dv                (w_rx_dv),
        .o_rx_byte              (),
        .o_spi_clk              (o_mcu_sclk),
        .o_spi_mosi             (o_mcu_mosi),
        .i_spi_miso             (1'b0)        // no mcu miso pin
    );

    // next frame must not complete before this one is out
    a_frame_overrun: assert property (
        @(posedge CLK) disable iff (!r_spi_master_adc_reset)
        i_frame_ready |-> (r_state == spi_adc_pkg::STREAM_IDLE && w_tx_ready)
    );

endmodule

// ==== current_logger_top.sv ====
// current_logger_top: adc sampler, range framer and mcu streamer wired to the pins
module current_logger_top #(
    parameter int ADC_CLKS_PER_HALF_BIT = 2,
    parameter int MCU_CLKS_PER_HALF_BIT = 2,
    parameter int CONV_PERIOD           = 400
) (
    input  logic CLK,
    input  logic r_spi_master_adc_reset,
    output logic o_adc_convst,
    output logic o_adc_cs_n,
    output logic o_adc_sclk,
    output logic o_adc_mosi,
    input  logic i_adc_miso,
    output logic o_mcu_cs_n,
    output logic o_mcu_sclk,
    output logic o_mcu_mosi,
    output logic o_range_ma,
    output logic o_range_ua,
    output logic o_range_na
);

    logic                                 w_sample_valid;
    logic [spi_adc_pkg::CODE_W-1:0]       w_sample_code;
    logic                                 w_frame_ready;
    logic [spi_adc_pkg::FRAME_ADDR_W-1:0] w_rd_addr;
    logic [7:0]                           w_rd_byte;

    adc_sampler #(
        .CONV_PERIOD       (CONV_PERIOD),
        .CLKS_PER_HALF_BIT (ADC_CLKS_PER_HALF_BIT)
    ) u_adc_sampler (
        .CLK                    (CLK),
        .r_spi_master_adc_reset (r_spi_master_adc_reset),
        .o_adc_convst           (o_adc_convst),
        .o_adc_cs_n             (o_adc_cs_n),
        .o_adc_sclk             (o_adc_sclk),
        .o_adc_mosi             (o_adc_mosi),
        .i_adc_miso             (i_adc_miso),
        .o_sample_valid         (w_sample_valid),
        .o_sample_code          (w_sample_code)
    );

    range_framer u_range_framer (
        .CLK                    (CLK),
        .r_spi_master_adc_reset (r_spi_master_adc_reset),
        .i_sample_valid         (w_sample_valid),
        .i_sample_code          (w_sample_code),
        .i_rd_addr              (w_rd_addr),
        .o_rd_byte              (w_rd_byte),
        .o_range_ma             (o_range_ma),
        .o_range_ua             (o_range_ua),
        .o_range_na             (o_range_na),
        .o_frame_ready          (w_frame_ready)
    );

    mcu_streamer #(
        .CLKS_PER_HALF_BIT (MCU_CLKS_PER_HALF_BIT)
    ) u_mcu_streamer (
        .CLK                    (CLK),
        .r_spi_master_adc_reset (r_spi_master_adc_reset),
        .i_frame_ready          (w_frame_ready),
        .o_rd_addr              (w_rd_addr),
        .i_rd_byte              (w_rd_byte),
        .o_mcu_cs_n             (o_mcu_cs_n),
        .o_mcu_sclk             (o_mcu_sclk),
        .o_mcu_mosi             (o_mcu_mosi)
    );

endmodule

// ==== tb_spi_models.sv ====
// tb_spi_models: adc slave serving seeded random codes, mcu slave byte capture
module tb_spi_models (
    input  logic        CLK,
    input  logic        i_adc_cs_n,
    input  logic        i_adc_sclk,
    input  logic        i_adc_mosi,
    output logic        o_adc_miso,
    output logic        o_adc_win,       // one cycle, adc cs_n just rose
    output logic [15:0] o_adc_win_bits,  // mosi bits seen in the window
    output logic [31:0] o_adc_win_word,  // last 32 mosi bits
    output logic [17:0] o_adc_code,      // code served in the window
    input  logic        i_mcu_cs_n,
    input  logic        i_mcu_sclk,
    input  logic        i_mcu_mosi,
    output logic        o_mcu_byte_dv,   // one cycle per captured byte
    output logic [7:0]  o_mcu_byte,
    output logic        o_mcu_win,       // one cycle, mcu cs_n just rose
    output logic [15:0] o_mcu_win_bits
);
    timeunit 1ns;
    timeprecision 100ps;

    integer      seed;
    integer      code_class;
    logic [17:0] code;
    logic [31:0] fill;       // don't-care bits after the code
    logic [31:0] miso_word;  // msb is on the wire
    logic [15:0] adc_bits;
    logic [15:0] mcu_bits;
    logic [7:0]  mcu_shift;
    logic        adc_cs_q;
    logic        adc_sclk_q;
    logic        mcu_cs_q;
    logic        mcu_sclk_q;

    initial begin
        seed           = 66;
        o_adc_miso     = 1'b0;
        o_adc_win      = 1'b0;
        o_mcu_byte_dv  = 1'b0;
        o_mcu_win      = 1'b0;
        adc_cs_q       = 1'b1;
        adc_sclk_q     = 1'b0;
        mcu_cs_q       = 1'b1;
        mcu_sclk_q     = 1'b0;
    end

    // adc side, all pin activity sampled and driven on the falling clk
    always @(negedge CLK) begin
        o_adc_win = 1'b0;
        if (adc_cs_q && !i_adc_cs_n) begin
            // new window, pick low / mid / high class so ranges move both ways
            code_class = {$random(seed)} % 3;
            case (code_class)
                0:       code = 18'({$random(seed)} % 2101);
                1:       code = 18'(2101 + {$random(seed)} % 217899);
                default: code = 18'(220000 + {$random(seed)} % 42144);
            endcase
            fill = $random(seed);
            // byte0 code[17:10], byte1 code[9:2], byte2 code[1:0] on top, byte3 junk
            miso_word      = {code[17:10], code[9:2], code[1:0], fill[5:0], fill[15:8]};
            o_adc_code     = code;
            o_adc_miso     = miso_word[31];
            adc_bits       = 16'd0;
            o_adc_win_word = 32'h0;
        end else if (!i_adc_cs_n) begin
            if (adc_sclk_q && !i_adc_sclk) begin  // falling sclk, next bit out
                miso_word  = {miso_word[30:0], 1'b0};
                o_adc_miso = miso_word[31];
            end
            if (!adc_sclk_q && i_adc_sclk) begin  // rising sclk, take mosi
                o_adc_win_word = {o_adc_win_word[30:0], i_adc_mosi};
                adc_bits       = adc_bits + 16'd1;
            end
        end else if (!adc_cs_q) begin
            o_adc_win      = 1'b1;
            o_adc_win_bits = adc_bits;
        end
        adc_cs_q   = i_adc_cs_n;
        adc_sclk_q = i_adc_sclk;
    end

    // mcu side, capture only
    always @(negedge CLK) begin
        o_mcu_byte_dv = 1'b0;
        o_mcu_win     = 1'b0;
        if (mcu_cs_q && !i_mcu_cs_n) begin
            mcu_bits = 16'd0;
        end else if (!i_mcu_cs_n) begin
            if (!mcu_sclk_q && i_mcu_sclk) begin
                mcu_shift = {mcu_shift[6:0], i_mcu_mosi};
                mcu_bits  = mcu_bits + 16'd1;
                if (mcu_bits[2:0] == 3'd0) begin  // eighth bit in
                    o_mcu_byte_dv = 1'b1;
                    o_mcu_byte    = mcu_shift;
                end
            end
        end else if (!mcu_cs_q) begin
            o_mcu_win      = 1'b1;
            o_mcu_win_bits = mcu_bits;
        end
        mcu_cs_q   = i_mcu_cs_n;
        mcu_sclk_q = i_mcu_sclk;
    end

endmodule

// ==== tb_current_logger.sv ====
// clock, reset, range and frame reference model, checks, pass or fail
module tb_current_logger;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CONV_PERIOD   = 400;
    localparam int LIMIT_LOW     = 2100;
    localparam int LIMIT_HIGH    = 220000;
    localparam int FRAMES        = 5;
    localparam int FRAME_TIMEOUT = 12000;  // cycles per frame against about 4000 expected

    logic        CLK;
    logic        r_spi_master_adc_reset;
    logic        adc_convst;
    logic        adc_cs_n;
    logic        adc_sclk;
    logic        adc_mosi;
    logic        adc_miso;
    logic        mcu_cs_n;
    logic        mcu_sclk;
    logic        mcu_mosi;
    logic        range_ma;
    logic        range_ua;
    logic        range_na;
    logic        adc_win;
    logic [15:0] adc_win_bits;
    logic [31:0] adc_win_word;
    logic [17:0] adc_code;
    logic        mcu_byte_dv;
    logic [7:0]  mcu_byte;
    logic        mcu_win;
    logic [15:0] mcu_win_bits;

    int         model_range   = 0;  // 0 mA, 1 uA, 2 nA
    int         sample_idx    = 0;
    int         adc_windows   = 0;
    int         mcu_frames    = 0;  // finished mcu windows
    int         mcu_starts    = 0;
    int         convst_seen   = 0;  // since last adc window opened
    int         bytes_checked = 0;
    logic [7:0] exp_bytes[$];       // expected mcu stream
    logic       run_checks    = 1'b0;
    logic       adc_cs_q      = 1'b1;
    logic       mcu_cs_q      = 1'b1;

    current_logger_top #(
        .ADC_CLKS_PER_HALF_BIT (2),
        .MCU_CLKS_PER_HALF_BIT (2),
        .CONV_PERIOD           (CONV_PERIOD)
    ) DUT (
        .CLK                    (CLK),
        .r_spi_master_adc_reset (r_spi_master_adc_reset),
        .o_adc_convst           (adc_convst),
        .o_adc_cs_n             (adc_cs_n),
        .o_adc_sclk             (adc_sclk),
        .o_adc_mosi             (adc_mosi),
        .i_adc_miso             (adc_miso),
        .o_mcu_cs_n             (mcu_cs_n),
        .o_mcu_sclk             (mcu_sclk),
        .o_mcu_mosi             (mcu_mosi),
        .o_range_ma             (range_ma),
        .o_range_ua             (range_ua),
        .o_range_na             (range_na)
    );

    tb_spi_models u_models (
        .CLK            (CLK),
        .i_adc_cs_n     (adc_cs_n),
        .i_adc_sclk     (adc_sclk),
        .i_adc_mosi     (adc_mosi),
        .o_adc_miso     (adc_miso),
        .o_adc_win      (adc_win),
        .o_adc_win_bits (adc_win_bits),
        .o_adc_win_word (adc_win_word),
        .o_adc_code     (adc_code),
        .i_mcu_cs_n     (mcu_cs_n),
        .i_mcu_sclk     (mcu_sclk),
        .i_mcu_mosi     (mcu_mosi),
        .o_mcu_byte_dv  (mcu_byte_dv),
        .o_mcu_byte     (mcu_byte),
        .o_mcu_win      (mcu_win),
        .o_mcu_win_bits (mcu_win_bits)
    );

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic fail_with_reason(input string what);
        $display("%s (t=%0t)", what, $time);
        stop_with_failure();
    endtask

    function automatic logic [2:0] range_bits(input int r);
        case (r)
            0:       return 3'b100;  // mA
            1:       return 3'b010;  // uA
            default: return 3'b001;  // nA
        endcase
    endfunction

    // one ladder step per sample with the high threshold first
    function automatic int range_after(input int r, input int code);
        if (code >= LIMIT_HIGH && r != 0) return r - 1;
        if (code < LIMIT_HIGH && code <= LIMIT_LOW && r != 2) return r + 1;
        return r;
    endfunction

    // packs one sample with the old range and steps the ladder
    task automatic model_sample(input logic [17:0] code);
        logic [23:0] wide;
        wide = {6'b0, code};
        exp_bytes.push_back({range_bits(model_range), 5'(sample_idx)});
        exp_bytes.push_back(wide[23:16]);
        exp_bytes.push_back(wide[15:8]);
        exp_bytes.push_back(wide[7:0]);
        model_range = range_after(model_range, int'(code));
        sample_idx  = (sample_idx + 1) % 10;
    endtask

    task automatic check_idle_pins();
        check_value("o_adc_cs_n", adc_cs_n, 1);
        check_value("o_mcu_cs_n", mcu_cs_n, 1);
        check_value("o_adc_convst", adc_convst, 0);
        check_value("{o_range_ma,o_range_ua,o_range_na}",
                    {range_ma, range_ua, range_na}, 3'b100);
    endtask

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // dut pins are stable on the falling edge
    always @(negedge CLK) begin
        int hot;
        hot = range_ma + range_ua + range_na;
        if (run_checks) begin
            check_value("range outputs one-hot count", hot, 1);
            if (adc_convst) begin
                convst_seen++;
                check_value("{o_range_ma,o_range_ua,o_range_na}",
                            {range_ma, range_ua, range_na}, range_bits(model_range));
            end
            if (adc_cs_q && !adc_cs_n) begin  // adc window opens
                check_value("convst pulses before adc window", convst_seen, 1);
                convst_seen = 0;
            end
            if (mcu_cs_q && !mcu_cs_n) begin  // one frame per ten samples
                check_value("adc windows before mcu frame", adc_windows,
                            10 * (mcu_starts + 1));
                mcu_starts++;
            end
        end
        adc_cs_q = adc_cs_n;
        mcu_cs_q = mcu_cs_n;
    end

    always @(posedge CLK) begin
        logic [7:0] exp_byte;
        if (adc_win) begin
            check_value("adc mosi bits per window", adc_win_bits, 32);
            if (adc_windows == 0) begin
                check_value("o_adc_mosi config word", adc_win_word, 32'hD014_000B);
            end else begin
                check_value("o_adc_mosi read word", adc_win_word, 32'h0);
            end
            model_sample(adc_code);
            adc_windows++;
        end
        if (mcu_byte_dv) begin
            if (exp_bytes.size() == 0) begin
                fail_with_reason("MCU received a byte with no ADC sample behind it");
            end else begin
                exp_byte = exp_bytes.pop_front();
                check_value($sformatf("o_mcu_mosi frame %0d byte %0d",
                                      bytes_checked / 40, bytes_checked % 40),
                            mcu_byte, exp_byte);
                bytes_checked++;
            end
        end
        if (mcu_win) begin
            check_value("mcu mosi bits per window", mcu_win_bits, 320);  // 40 bytes
            mcu_frames++;
        end
    end

    initial begin
        int cycles;
        r_spi_master_adc_reset = 1'b0;
        repeat (10) @(negedge CLK);
        check_idle_pins();
        r_spi_master_adc_reset = 1'b1;
        @(negedge CLK);
        check_idle_pins();
        run_checks = 1'b1;
        for (int f = 0; f < FRAMES; f++) begin
            cycles = 0;
            while (mcu_frames <= f) begin
                @(negedge CLK);
                cycles++;
                if (cycles > FRAME_TIMEOUT) begin
                    fail_with_reason("timed out waiting for a complete MCU frame");
                end
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== sources.f ====
spi_adc_pkg.sv
spi_byte_master.sv
adc_sampler.sv
range_framer.sv
mcu_streamer.sv
current_logger_top.sv
tb_spi_models.sv
tb_current_logger.sv
